// File: st_buffer_pkg.sv
// Store buffer widths, entry/drain state and store response enums, entry payload struct

package st_buffer_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------
  localparam int PADDR_W  = 32;
  localparam int DATA_W   = 64;
  localparam int STRB_W   = DATA_W / 8;
  localparam int LINE_LSB = 3;
  localparam int LINE_W   = PADDR_W - LINE_LSB;

  // Physical address without the byte offset
  typedef logic [LINE_W-1:0] line_addr_t;

  // ------------------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    ST_RESP_ALLOC = 2'd0,
    ST_RESP_MERGE = 2'd1,
    ST_RESP_FULL  = 2'd2
  } st_resp_e;

  typedef enum logic [1:0] {
    ENTRY_FREE    = 2'd0,
    ENTRY_PENDING = 2'd1,
    ENTRY_ISSUED  = 2'd2
  } entry_state_e;

  typedef enum logic [1:0] {
    DRAIN_IDLE = 2'd0,
    DRAIN_REQ  = 2'd1,
    DRAIN_RESP = 2'd2
  } drain_state_e;

  // Line, byte strobes and data of one buffered store
  typedef struct packed {
    line_addr_t        line;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] data;
  } st_payload_t;

endpackage

// File: st_buffer_ifs.sv
// Per-entry store buffer interface st_entry_if with feed, drain, watch and entry modports
`timescale 1ns/1ns

interface st_entry_if;

  // Allocator side
  logic                        load;
  logic                        merge;
  st_buffer_pkg::st_payload_t  new_payload;

  // Drain side
  logic                        issue;
  logic                        done;
  logic                        retry;

  // Entry contents
  st_buffer_pkg::entry_state_e state;
  st_buffer_pkg::st_payload_t  payload;

  // Allocator writes new stores or merges into an entry
  modport feed (
    output load,
    output merge,
    output new_payload
  );

  // Drain moves the entry through issue and completion
  modport drain (
    output issue,
    output done,
    output retry
  );

  // Read-only view for merge search and forwarding
  modport watch (
    input state,
    input payload
  );

  modport entry (
    input  load,
    input  merge,
    input  new_payload,
    input  issue,
    input  done,
    input  retry,
    output state,
    output payload
  );

endinterface

// File: st_buffer_alloc.sv
// Store buffer allocator: input pointer, merge search, occupancy count and store response
`timescale 1ns/1ns

module st_buffer_alloc #(
  parameter int ENTRY_NUM = 4
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_st_valid,
  input  st_buffer_pkg::st_payload_t   i_st_payload,
  output st_buffer_pkg::st_resp_e      o_st_resp,
  input  logic                         i_free,
  input  logic [$clog2(ENTRY_NUM)-1:0] i_out_ptr,
  output logic [$clog2(ENTRY_NUM)-1:0] o_in_ptr,
  st_entry_if.feed                     entry_ifs [ENTRY_NUM],
  st_entry_if.watch                    watch_ifs [ENTRY_NUM]
);

  localparam int PTR_W = $clog2(ENTRY_NUM);
  localparam int CNT_W = $clog2(ENTRY_NUM + 1);

  logic [PTR_W-1:0]            r_in_ptr;
  logic [CNT_W-1:0]            r_count;
  logic [ENTRY_NUM-1:0]        w_match;
  logic [PTR_W-1:0]            w_merge_idx;
  logic                        w_merge_hit;
  logic                        w_can_alloc;
  logic                        w_alloc;
  logic                        w_merge;
  st_buffer_pkg::entry_state_e w_state [ENTRY_NUM];

  // ------------------------------------------------------------------------
  // Per-entry match and control
  // ------------------------------------------------------------------------
  // The head entry, when pending, is being issued this cycle and takes no merge
  for (genvar g = 0; g < ENTRY_NUM; g++) begin : entry_loop
    assign w_state[g] = watch_ifs[g].state;
    assign w_match[g] = (watch_ifs[g].state == st_buffer_pkg::ENTRY_PENDING) &&
                        (i_out_ptr != PTR_W'(g)) &&
                        (watch_ifs[g].payload.line == i_st_payload.line);

    assign entry_ifs[g].load        = w_alloc && (r_in_ptr == PTR_W'(g));
    assign entry_ifs[g].merge       = w_merge && (w_merge_idx == PTR_W'(g));
    assign entry_ifs[g].new_payload = i_st_payload;
  end

  // Walk back from the input pointer, the last hit is the youngest
  always_comb begin
    int idx;
    w_merge_hit = 1'b0;
    w_merge_idx = '0;
    for (int k = ENTRY_NUM; k >= 1; k--) begin
      idx = (int'(r_in_ptr) + ENTRY_NUM - k) % ENTRY_NUM;
      if (w_match[idx]) begin
        w_merge_hit = 1'b1;
        w_merge_idx = PTR_W'(idx);
      end
    end
  end

  // ------------------------------------------------------------------------
  // Decision
  // ------------------------------------------------------------------------
  assign w_can_alloc = (r_count < CNT_W'(ENTRY_NUM)) &&
                       (w_state[r_in_ptr] == st_buffer_pkg::ENTRY_FREE);
  assign w_merge     = i_st_valid && w_merge_hit;
  assign w_alloc     = i_st_valid && !w_merge_hit && w_can_alloc;

  always_comb begin
    if (w_merge_hit) begin
      o_st_resp = st_buffer_pkg::ST_RESP_MERGE;
    end else if (w_can_alloc) begin
      o_st_resp = st_buffer_pkg::ST_RESP_ALLOC;
    end else begin
      o_st_resp = st_buffer_pkg::ST_RESP_FULL;
    end
  end

  // Input pointer and occupancy
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (w_alloc) begin
        r_in_ptr <= (r_in_ptr == PTR_W'(ENTRY_NUM - 1)) ? '0 : r_in_ptr + PTR_W'(1);
      end
      case ({w_alloc, i_free})
        2'b10:   r_count <= r_count + CNT_W'(1);
        2'b01:   r_count <= r_count - CNT_W'(1);
        default: r_count <= r_count;
      endcase
    end
  end

  assign o_in_ptr = r_in_ptr;

endmodule

// File: st_buffer_entry.sv
// Store buffer entry: line address, byte strobes, data and entry state machine
`timescale 1ns/1ns

module st_buffer_entry (
  input logic       i_clk,
  input logic       i_reset_n,
  st_entry_if.entry entry_if
);

  st_buffer_pkg::entry_state_e        r_state;
  st_buffer_pkg::entry_state_e        w_state_next;
  st_buffer_pkg::st_payload_t         r_payload;
  logic [st_buffer_pkg::DATA_W-1:0]   w_data_base;
  logic [st_buffer_pkg::DATA_W-1:0]   w_data_next;

  // ------------------------------------------------------------------------
  // State machine
  // ------------------------------------------------------------------------
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      st_buffer_pkg::ENTRY_FREE: begin
        if (entry_if.load) begin
          w_state_next = st_buffer_pkg::ENTRY_PENDING;
        end
      end
      st_buffer_pkg::ENTRY_PENDING: begin
        if (entry_if.issue) begin
          w_state_next = st_buffer_pkg::ENTRY_ISSUED;
        end
      end
      st_buffer_pkg::ENTRY_ISSUED: begin
        if (entry_if.done) begin
          w_state_next = st_buffer_pkg::ENTRY_FREE;
        end else if (entry_if.retry) begin
          // Conflict, go round again
          w_state_next = st_buffer_pkg::ENTRY_PENDING;
        end
      end
      default: w_state_next = st_buffer_pkg::ENTRY_FREE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= st_buffer_pkg::ENTRY_FREE;
    end else begin
      r_state <= w_state_next;
    end
  end

  // ------------------------------------------------------------------------
  // Payload
  // ------------------------------------------------------------------------
  // New allocation starts from zero so unwritten bytes read back as 0
  assign w_data_base = entry_if.load ? '0 : r_payload.data;

  always_comb begin
    for (int b = 0; b < st_buffer_pkg::STRB_W; b++) begin
      w_data_next[b*8 +: 8] = entry_if.new_payload.strb[b] ?
                              entry_if.new_payload.data[b*8 +: 8] : w_data_base[b*8 +: 8];
    end
  end

  always_ff @(posedge i_clk) begin
    if (entry_if.load) begin
      r_payload.line <= entry_if.new_payload.line;
      r_payload.strb <= entry_if.new_payload.strb;
      r_payload.data <= w_data_next;
    end else if (entry_if.merge) begin
      r_payload.strb <= r_payload.strb | entry_if.new_payload.strb;
      r_payload.data <= w_data_next;
    end
  end

  assign entry_if.state   = r_state;
  assign entry_if.payload = r_payload;

endmodule

// File: st_buffer_drain.sv
// Store buffer drain: output pointer, head entry issue to the L1D and response/retry handling
`timescale 1ns/1ns

module st_buffer_drain #(
  parameter int ENTRY_NUM = 4
) (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  st_entry_if.drain                         entry_ifs [ENTRY_NUM],
  st_entry_if.watch                         watch_ifs [ENTRY_NUM],
  output logic [$clog2(ENTRY_NUM)-1:0]      o_out_ptr,
  output logic                              o_free,
  output logic                              o_l1d_wr_valid,
  input  logic                              i_l1d_wr_ready,
  output logic [st_buffer_pkg::PADDR_W-1:0] o_l1d_wr_paddr,
  output logic [st_buffer_pkg::DATA_W-1:0]  o_l1d_wr_data,
  output logic [st_buffer_pkg::STRB_W-1:0]  o_l1d_wr_strb,
  input  logic                              i_l1d_resp_valid,
  input  logic                              i_l1d_resp_conflict
);

  localparam int PTR_W = $clog2(ENTRY_NUM);

  st_buffer_pkg::drain_state_e r_state;
  st_buffer_pkg::drain_state_e w_state_next;
  logic [PTR_W-1:0]            r_out_ptr;
  st_buffer_pkg::st_payload_t  r_wr_payload;
  st_buffer_pkg::entry_state_e w_ent_state [ENTRY_NUM];
  st_buffer_pkg::st_payload_t  w_ent_payload [ENTRY_NUM];
  logic                        w_issue;
  logic                        w_done;
  logic                        w_retry;

  for (genvar g = 0; g < ENTRY_NUM; g++) begin : entry_loop
    assign w_ent_state[g]     = watch_ifs[g].state;
    assign w_ent_payload[g]   = watch_ifs[g].payload;
    assign entry_ifs[g].issue = w_issue && (r_out_ptr == PTR_W'(g));
    assign entry_ifs[g].done  = w_done && (r_out_ptr == PTR_W'(g));
    assign entry_ifs[g].retry = w_retry && (r_out_ptr == PTR_W'(g));
  end

  assign w_issue = (r_state == st_buffer_pkg::DRAIN_IDLE) &&
                   (w_ent_state[r_out_ptr] == st_buffer_pkg::ENTRY_PENDING);
  assign w_done  = (r_state == st_buffer_pkg::DRAIN_RESP) && i_l1d_resp_valid &&
                   !i_l1d_resp_conflict;
  assign w_retry = (r_state == st_buffer_pkg::DRAIN_RESP) && i_l1d_resp_valid &&
                   i_l1d_resp_conflict;

  // ------------------------------------------------------------------------
  // Drain FSM
  // ------------------------------------------------------------------------
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      st_buffer_pkg::DRAIN_IDLE: if (w_issue) w_state_next = st_buffer_pkg::DRAIN_REQ;
      st_buffer_pkg::DRAIN_REQ:  if (i_l1d_wr_ready) w_state_next = st_buffer_pkg::DRAIN_RESP;
      st_buffer_pkg::DRAIN_RESP: if (i_l1d_resp_valid) w_state_next = st_buffer_pkg::DRAIN_IDLE;
      default:                   w_state_next = st_buffer_pkg::DRAIN_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state   <= st_buffer_pkg::DRAIN_IDLE;
      r_out_ptr <= '0;
    end else begin
      r_state <= w_state_next;
      if (w_done) begin
        r_out_ptr <= (r_out_ptr == PTR_W'(ENTRY_NUM - 1)) ? '0 : r_out_ptr + PTR_W'(1);
      end
    end
  end

  // Request held stable from here until the response
  always_ff @(posedge i_clk) begin
    if (w_issue) begin
      r_wr_payload <= w_ent_payload[r_out_ptr];
    end
  end

  assign o_l1d_wr_valid = (r_state == st_buffer_pkg::DRAIN_REQ);
  assign o_l1d_wr_paddr = {r_wr_payload.line, {st_buffer_pkg::LINE_LSB{1'b0}}};
  assign o_l1d_wr_data  = r_wr_payload.data;
  assign o_l1d_wr_strb  = r_wr_payload.strb;
  assign o_free         = w_done;
  assign o_out_ptr      = r_out_ptr;

endmodule

// File: st_buffer_fwd.sv
// Store buffer forwarder: youngest matching entry bytes for one load address
`timescale 1ns/1ns

module st_buffer_fwd #(
  parameter int ENTRY_NUM = 4
) (
  input  logic [st_buffer_pkg::PADDR_W-1:0] i_ld_paddr,
  input  logic [$clog2(ENTRY_NUM)-1:0]      i_in_ptr,
  input  logic [$clog2(ENTRY_NUM)-1:0]      i_out_ptr,
  st_entry_if.watch                         entry_ifs [ENTRY_NUM],
  output logic                              o_fwd_valid,
  output logic [st_buffer_pkg::STRB_W-1:0]  o_fwd_strb,
  output logic [st_buffer_pkg::DATA_W-1:0]  o_fwd_data
);

  st_buffer_pkg::line_addr_t  w_ld_line;
  logic [ENTRY_NUM-1:0]       w_hit;
  st_buffer_pkg::st_payload_t w_payload [ENTRY_NUM];

  assign w_ld_line = i_ld_paddr[st_buffer_pkg::PADDR_W-1:st_buffer_pkg::LINE_LSB];

  for (genvar g = 0; g < ENTRY_NUM; g++) begin : entry_loop
    assign w_payload[g] = entry_ifs[g].payload;
    assign w_hit[g]     = (entry_ifs[g].state != st_buffer_pkg::ENTRY_FREE) &&
                          (entry_ifs[g].payload.line == w_ld_line);
  end

  // ------------------------------------------------------------------------
  // Age-ordered select
  // ------------------------------------------------------------------------
  // Oldest first from the head up to the input pointer, last hit wins
  always_comb begin
    int   idx;
    logic live;
    live        = 1'b1;
    o_fwd_valid = 1'b0;
    o_fwd_strb  = '0;
    o_fwd_data  = '0;
    for (int k = 0; k < ENTRY_NUM; k++) begin
      idx = (int'(i_out_ptr) + k) % ENTRY_NUM;
      // Full buffer has both pointers equal, so only stop past the head
      if ((k != 0) && (idx == int'(i_in_ptr))) begin
        live = 1'b0;
      end
      if (live && w_hit[idx]) begin
        o_fwd_valid = 1'b1;
        o_fwd_strb  = w_payload[idx].strb;
        o_fwd_data  = w_payload[idx].data;
      end
    end
  end

endmodule

// File: st_buffer.sv
// Store buffer top level: allocator, entry array, L1D drain and load forwarder
`timescale 1ns/1ns

module st_buffer #(
  parameter int ENTRY_NUM = 4
) (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  // Committed store
  input  logic                              i_st_valid,
  input  logic [st_buffer_pkg::PADDR_W-1:0] i_st_paddr,
  input  logic [st_buffer_pkg::STRB_W-1:0]  i_st_strb,
  input  logic [st_buffer_pkg::DATA_W-1:0]  i_st_data,
  output st_buffer_pkg::st_resp_e           o_st_resp,
  // L1D write
  output logic                              o_l1d_wr_valid,
  input  logic                              i_l1d_wr_ready,
  output logic [st_buffer_pkg::PADDR_W-1:0] o_l1d_wr_paddr,
  output logic [st_buffer_pkg::DATA_W-1:0]  o_l1d_wr_data,
  output logic [st_buffer_pkg::STRB_W-1:0]  o_l1d_wr_strb,
  input  logic                              i_l1d_resp_valid,
  input  logic                              i_l1d_resp_conflict,
  // Load forward check
  input  logic [st_buffer_pkg::PADDR_W-1:0] i_ld_paddr,
  output logic                              o_fwd_valid,
  output logic [st_buffer_pkg::STRB_W-1:0]  o_fwd_strb,
  output logic [st_buffer_pkg::DATA_W-1:0]  o_fwd_data
);

  localparam int PTR_W = $clog2(ENTRY_NUM);

  st_buffer_pkg::st_payload_t w_st_payload;
  logic [PTR_W-1:0]           w_in_ptr;
  logic [PTR_W-1:0]           w_out_ptr;
  logic                       w_free;

  st_entry_if entry_ifs [ENTRY_NUM] ();

  assign w_st_payload.line = i_st_paddr[st_buffer_pkg::PADDR_W-1:st_buffer_pkg::LINE_LSB];
  assign w_st_payload.strb = i_st_strb;
  assign w_st_payload.data = i_st_data;

  st_buffer_alloc #(
    .ENTRY_NUM (ENTRY_NUM)
  ) u_alloc (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_st_valid   (i_st_valid),
    .i_st_payload (w_st_payload),
    .o_st_resp    (o_st_resp),
    .i_free       (w_free),
    .i_out_ptr    (w_out_ptr),
    .o_in_ptr     (w_in_ptr),
    .entry_ifs    (entry_ifs),
    .watch_ifs    (entry_ifs)
  );

  for (genvar g = 0; g < ENTRY_NUM; g++) begin : entry_loop
    st_buffer_entry u_entry (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .entry_if  (entry_ifs[g])
    );
  end

  st_buffer_drain #(
    .ENTRY_NUM (ENTRY_NUM)
  ) u_drain (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .entry_ifs           (entry_ifs),
    .watch_ifs           (entry_ifs),
    .o_out_ptr           (w_out_ptr),
    .o_free              (w_free),
    .o_l1d_wr_valid      (o_l1d_wr_valid),
    .i_l1d_wr_ready      (i_l1d_wr_ready),
    .o_l1d_wr_paddr      (o_l1d_wr_paddr),
    .o_l1d_wr_data       (o_l1d_wr_data),
    .o_l1d_wr_strb       (o_l1d_wr_strb),
    .i_l1d_resp_valid    (i_l1d_resp_valid),
    .i_l1d_resp_conflict (i_l1d_resp_conflict)
  );

  st_buffer_fwd #(
    .ENTRY_NUM (ENTRY_NUM)
  ) u_fwd (
    .i_ld_paddr  (i_ld_paddr),
    .i_in_ptr    (w_in_ptr),
    .i_out_ptr   (w_out_ptr),
    .entry_ifs   (entry_ifs),
    .o_fwd_valid (o_fwd_valid),
    .o_fwd_strb  (o_fwd_strb),
    .o_fwd_data  (o_fwd_data)
  );

endmodule

// File: tb_st_buffer.sv
// Store buffer testbench: cache responder, reference queue model and directed tests
`timescale 1ns/1ns

module tb_st_buffer;

  localparam int ENTRY_NUM = 4;
  localparam int WAIT_MAX  = 2000;

  logic                    i_clk = 1'b0;
  logic                    i_reset_n;
  logic                    i_st_valid;
  logic [31:0]             i_st_paddr;
  logic [7:0]              i_st_strb;
  logic [63:0]             i_st_data;
  st_buffer_pkg::st_resp_e o_st_resp;
  logic                    o_l1d_wr_valid;
  logic                    i_l1d_wr_ready = 1'b0;
  logic [31:0]             o_l1d_wr_paddr;
  logic [63:0]             o_l1d_wr_data;
  logic [7:0]              o_l1d_wr_strb;
  logic                    i_l1d_resp_valid = 1'b0;
  logic                    i_l1d_resp_conflict = 1'b0;
  logic [31:0]             i_ld_paddr;
  logic                    o_fwd_valid;
  logic [7:0]              o_fwd_strb;
  logic [63:0]             o_fwd_data;

  int seed = 80042;
  int checks = 0;
  int errors = 0;
  int wr_count = 0;
  int retry_count = 0;

  // Cache model settings, ready mode 0 low, 1 high, 2 random
  int ready_mode = 1;
  int fixed_lat = 0;
  bit rand_lat = 1'b0;
  bit rand_conflict = 1'b0;
  int conflict_at = -1;

  // Cache model internals
  bit rsp_busy = 1'b0;
  int rsp_wait = 0;
  int rsp_count = 0;

  // Expected buffer contents, oldest first
  st_buffer_pkg::line_addr_t mq_line[$];
  logic [7:0]                mq_strb[$];
  logic [63:0]               mq_data[$];

  logic [31:0] last_wr_paddr;
  logic [63:0] last_wr_data;
  logic [7:0]  last_wr_strb;

  st_buffer #(
    .ENTRY_NUM (ENTRY_NUM)
  ) dut (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_st_valid          (i_st_valid),
    .i_st_paddr          (i_st_paddr),
    .i_st_strb           (i_st_strb),
    .i_st_data           (i_st_data),
    .o_st_resp           (o_st_resp),
    .o_l1d_wr_valid      (o_l1d_wr_valid),
    .i_l1d_wr_ready      (i_l1d_wr_ready),
    .o_l1d_wr_paddr      (o_l1d_wr_paddr),
    .o_l1d_wr_data       (o_l1d_wr_data),
    .o_l1d_wr_strb       (o_l1d_wr_strb),
    .i_l1d_resp_valid    (i_l1d_resp_valid),
    .i_l1d_resp_conflict (i_l1d_resp_conflict),
    .i_ld_paddr          (i_ld_paddr),
    .o_fwd_valid         (o_fwd_valid),
    .o_fwd_strb          (o_fwd_strb),
    .o_fwd_data          (o_fwd_data)
  );

  always #50 i_clk = ~i_clk;

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------------------------------
  // Cache responder
  // --------------------------------------------------------------------------
  always @(posedge i_clk) begin
    int rnd;
    bit conflict;
    if (!i_reset_n) begin
      i_l1d_wr_ready      <= 1'b0;
      i_l1d_resp_valid    <= 1'b0;
      i_l1d_resp_conflict <= 1'b0;
      rsp_busy  = 1'b0;
      rsp_wait  = 0;
      rsp_count = 0;
    end else begin
      i_l1d_resp_valid    <= 1'b0;
      i_l1d_resp_conflict <= 1'b0;
      case (ready_mode)
        0: i_l1d_wr_ready <= 1'b0;
        1: i_l1d_wr_ready <= 1'b1;
        default: begin
          rnd = $random(seed);
          i_l1d_wr_ready <= rnd[0];
        end
      endcase
      if (o_l1d_wr_valid && i_l1d_wr_ready) begin
        rsp_busy = 1'b1;
        rnd      = rand_lat ? $random(seed) : 0;
        rsp_wait = rand_lat ? (rnd & 3) : fixed_lat;
      end
      if (rsp_busy) begin
        if (rsp_wait == 0) begin
          rnd      = rand_conflict ? $random(seed) : 1;
          conflict = (rsp_count == conflict_at) || ((rnd & 3) == 0);
          i_l1d_resp_valid    <= 1'b1;
          i_l1d_resp_conflict <= conflict;
          rsp_count = rsp_count + 1;
          rsp_busy  = 1'b0;
        end else begin
          rsp_wait = rsp_wait - 1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Reference queue, updated ahead of the edge that acts on it
  // --------------------------------------------------------------------------
  always @(negedge i_clk) begin
    int                        hit;
    st_buffer_pkg::st_resp_e   exp_resp;
    st_buffer_pkg::line_addr_t line;
    logic [63:0]               merged;
    if (i_reset_n) begin
      if (i_st_valid) begin
        line = i_st_paddr[31:3];
        hit  = -1;
        // Head entry is already on its way to the cache
        for (int k = 1; k < mq_line.size(); k++) begin
          if (mq_line[k] == line) begin
            hit = k;
          end
        end
        if (hit >= 0) begin
          exp_resp = st_buffer_pkg::ST_RESP_MERGE;
          merged   = mq_data[hit];
        end else begin
          exp_resp = (mq_line.size() < ENTRY_NUM) ? st_buffer_pkg::ST_RESP_ALLOC :
                                                    st_buffer_pkg::ST_RESP_FULL;
          merged   = '0;
        end
        check_val(64'(o_st_resp), 64'(exp_resp), "store response");
        for (int b = 0; b < 8; b++) begin
          if (i_st_strb[b]) begin
            merged[b*8 +: 8] = i_st_data[b*8 +: 8];
          end
        end
        if (exp_resp == st_buffer_pkg::ST_RESP_MERGE) begin
          mq_data[hit] = merged;
          mq_strb[hit] = mq_strb[hit] | i_st_strb;
        end else if (exp_resp == st_buffer_pkg::ST_RESP_ALLOC) begin
          mq_line.push_back(line);
          mq_strb.push_back(i_st_strb);
          mq_data.push_back(merged);
        end
      end
      if (o_l1d_wr_valid && i_l1d_wr_ready) begin
        if (mq_line.size() == 0) begin
          errors++;
          $display("Cache write at %0t ns with no buffered store", $time);
        end else begin
          check_val(64'(o_l1d_wr_paddr), 64'({mq_line[0], 3'b000}), "write address");
          check_val(o_l1d_wr_data, mq_data[0], "write data");
          check_val(64'(o_l1d_wr_strb), 64'(mq_strb[0]), "write strobes");
        end
        last_wr_paddr = o_l1d_wr_paddr;
        last_wr_data  = o_l1d_wr_data;
        last_wr_strb  = o_l1d_wr_strb;
        wr_count++;
      end
      if (i_l1d_resp_valid) begin
        if (i_l1d_resp_conflict) begin
          retry_count++;
        end else if (mq_line.size() != 0) begin
          mq_line.delete(0);
          mq_strb.delete(0);
          mq_data.delete(0);
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic set_cache(input int rdy, input int lat, input bit rlat, input bit rconf,
                           input bit force_conf);
    @(negedge i_clk);
    ready_mode    = rdy;
    fixed_lat     = lat;
    rand_lat      = rlat;
    rand_conflict = rconf;
    conflict_at   = force_conf ? rsp_count : -1;
  endtask

  task automatic send_store(input logic [31:0] paddr, input logic [7:0] strb,
                            input logic [63:0] data, output st_buffer_pkg::st_resp_e resp);
    @(posedge i_clk);
    i_st_valid <= 1'b1;
    i_st_paddr <= paddr;
    i_st_strb  <= strb;
    i_st_data  <= data;
    @(negedge i_clk);
    resp = o_st_resp;
    @(posedge i_clk);
    i_st_valid <= 1'b0;
  endtask

  task automatic wait_drained(input string what);
    int n;
    n = 0;
    @(posedge i_clk);
    while ((mq_line.size() != 0 || o_l1d_wr_valid) && n < WAIT_MAX) begin
      @(posedge i_clk);
      n++;
    end
    if (n >= WAIT_MAX) begin
      errors++;
      $display("Timeout: the buffer did not drain during %s", what);
    end
  endtask

  task automatic check_fwd(input logic [31:0] paddr, input logic exp_valid,
                           input logic [7:0] exp_strb, input logic [63:0] exp_data);
    @(posedge i_clk);
    i_ld_paddr <= paddr;
    @(negedge i_clk);
    check_val(64'(o_fwd_valid), 64'(exp_valid), "forward valid");
    check_val(64'(o_fwd_strb), 64'(exp_strb), "forward strobes");
    if (exp_valid) begin
      check_val(o_fwd_data, exp_data, "forward data");
    end
  endtask

  task automatic end_test(input string name, input int err0);
    @(posedge i_clk);
    $display("%-22s finished with %0d errors", name, errors - err0);
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic store_once();
    int err0;
    int wr0;
    st_buffer_pkg::st_resp_e resp;
    err0 = errors;
    wr0  = wr_count;
    set_cache(1, 1, 1'b0, 1'b0, 1'b0);
    send_store(32'h0000_1005, 8'h30, 64'h0123_4567_89ab_cdef, resp);
    check_val(64'(resp), 64'(st_buffer_pkg::ST_RESP_ALLOC), "single store response");
    wait_drained("single store");
    check_val(64'(wr_count - wr0), 64'd1, "single store write count");
    check_val(64'(last_wr_paddr), 64'h1000, "single store address");
    check_val(64'(last_wr_strb), 64'h30, "single store strobes");
    check_val(last_wr_data, 64'h0000_4567_0000_0000, "single store data");
    end_test("single store", err0);
  endtask

  task automatic merge_pending();
    int err0;
    int wr0;
    logic [63:0] d1;
    logic [63:0] d2;
    st_buffer_pkg::st_resp_e resp;
    err0 = errors;
    wr0  = wr_count;
    d1   = 64'h1111_2222_3333_4444;
    d2   = 64'haaaa_bbbb_cccc_dddd;
    set_cache(0, 1, 1'b0, 1'b0, 1'b0);
    send_store(32'h0000_5000, 8'hff, 64'h5555_6666_7777_8888, resp);
    send_store(32'h0000_5008, 8'h0f, d1, resp);
    check_val(64'(resp), 64'(st_buffer_pkg::ST_RESP_ALLOC), "merge base response");
    send_store(32'h0000_500c, 8'h3c, d2, resp);
    check_val(64'(resp), 64'(st_buffer_pkg::ST_RESP_MERGE), "merge response");
    set_cache(1, 1, 1'b0, 1'b0, 1'b0);
    wait_drained("merge");
    check_val(64'(wr_count - wr0), 64'd2, "merge write count");
    check_val(64'(last_wr_strb), 64'h3f, "merged strobes");
    // Newer bytes 2 to 5 over the older bytes 0 and 1
    check_val(last_wr_data, {16'h0, d2[47:16], d1[15:0]}, "merged data");
    end_test("merge into pending", err0);
  endtask

  task automatic fill_until_full();
    int err0;
    int wr0;
    st_buffer_pkg::st_resp_e resp;
    err0 = errors;
    wr0  = wr_count;
    set_cache(0, 0, 1'b0, 1'b0, 1'b0);
    for (int n = 0; n < ENTRY_NUM; n++) begin
      send_store(32'h0000_6000 + 32'(n * 8), 8'h01 << n, 64'(n + 1) * 64'h0101, resp);
      check_val(64'(resp), 64'(st_buffer_pkg::ST_RESP_ALLOC), "fill response");
    end
    for (int n = 0; n < 2; n++) begin
      send_store(32'h0000_6100, 8'hff, 64'hdead_beef_0000_0001, resp);
      check_val(64'(resp), 64'(st_buffer_pkg::ST_RESP_FULL), "full response");
    end
    set_cache(1, 0, 1'b0, 1'b0, 1'b0);
    wait_drained("fill");
    check_val(64'(wr_count - wr0), 64'(ENTRY_NUM), "fill write count");
    send_store(32'h0000_6100, 8'hff, 64'hdead_beef_0000_0001, resp);
    check_val(64'(resp), 64'(st_buffer_pkg::ST_RESP_ALLOC), "store after drain");
    wait_drained("fill retry");
    end_test("fill until full", err0);
  endtask

  task automatic retry_on_conflict();
    int err0;
    int wr0;
    int rt0;
    st_buffer_pkg::st_resp_e resp;
    err0 = errors;
    wr0  = wr_count;
    rt0  = retry_count;
    set_cache(1, 2, 1'b0, 1'b0, 1'b1);
    send_store(32'h0000_3000, 8'hff, 64'hfeed_face_cafe_f00d, resp);
    send_store(32'h0000_3008, 8'h0f, 64'h0000_0000_1234_5678, resp);
    wait_drained("conflict");
    check_val(64'(retry_count - rt0), 64'd1, "conflict retry count");
    check_val(64'(wr_count - wr0), 64'd3, "conflict write count");
    check_val(64'(last_wr_paddr), 64'h3008, "younger write last");
    end_test("conflict retry", err0);
  endtask

  task automatic forward_load();
    int err0;
    st_buffer_pkg::st_resp_e resp;
    err0 = errors;
    set_cache(0, 0, 1'b0, 1'b0, 1'b0);
    send_store(32'h0000_4000, 8'h0f, 64'h1122_3344_5566_7788, resp);
    send_store(32'h0000_4010, 8'hf0, 64'h99aa_bbcc_ddee_ff00, resp);
    check_fwd(32'h0000_4014, 1'b1, 8'hf0, 64'h99aa_bbcc_0000_0000);
    check_fwd(32'h0000_4003, 1'b1, 8'h0f, 64'h0000_0000_5566_7788);
    check_fwd(32'h0000_4008, 1'b0, 8'h00, 64'h0);
    set_cache(1, 0, 1'b0, 1'b0, 1'b0);
    wait_drained("forward");
    check_fwd(32'h0000_4010, 1'b0, 8'h00, 64'h0);
    end_test("load forwarding", err0);
  endtask

  task automatic random_traffic();
    int err0;
    int rnd;
    int tries;
    logic [31:0] paddr;
    logic [7:0]  strb;
    logic [63:0] data;
    st_buffer_pkg::st_resp_e resp;
    err0 = errors;
    set_cache(2, 0, 1'b1, 1'b1, 1'b0);
    for (int n = 0; n < 40; n++) begin
      @(negedge i_clk);
      rnd   = $random(seed);
      paddr = {27'h100, rnd[4:3], rnd[2:0]};
      strb  = rnd[15:8];
      data  = {$random(seed), $random(seed)};
      tries = 0;
      resp  = st_buffer_pkg::ST_RESP_FULL;
      // Full buffer, present the same store again
      while (resp == st_buffer_pkg::ST_RESP_FULL && tries < 200) begin
        send_store(paddr, strb, data, resp);
        tries++;
      end
      if (resp == st_buffer_pkg::ST_RESP_FULL) begin
        errors++;
        $display("Timeout: random store %0d was never accepted", n);
      end
    end
    set_cache(1, 0, 1'b0, 1'b0, 1'b0);
    wait_drained("random traffic");
    end_test("random traffic", err0);
  endtask

  initial begin
    i_reset_n  = 1'b0;
    i_st_valid = 1'b0;
    i_st_paddr = '0;
    i_st_strb  = '0;
    i_st_data  = '0;
    i_ld_paddr = '0;
    repeat (16) @(posedge i_clk);
    i_reset_n <= 1'b1;
    store_once();
    merge_pending();
    fill_until_full();
    retry_on_conflict();
    forward_load();
    random_traffic();
    $display("Checks: %0d, errors: %0d, cache writes: %0d, retries: %0d",
             checks, errors, wr_count, retry_count);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: files.f
st_buffer_pkg.sv
st_buffer_ifs.sv
st_buffer_alloc.sv
st_buffer_entry.sv
st_buffer_drain.sv
st_buffer_fwd.sv
st_buffer.sv
tb_st_buffer.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the store buffer simulation with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_st_buffer -f files.f \
    -o tb_st_buffer > build.log 2>&1; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_st_buffer > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi

if ! grep -q "Test completed successfully" sim.log; then
  echo "No pass message in sim.log"
  exit 1
fi

exit 0
